//--- flist.f
siggen_pkg.sv
siggen_settings.sv
siggen_sine.sv
siggen_source_select.sv
siggen_packetizer.sv
siggen_top.sv
tb_siggen.sv

//--- run.sh
#!/bin/sh
# Build and run the signal generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_siggen -o tb_siggen \
  && ./obj_dir/tb_siggen > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

//--- siggen_packetizer.sv
////////////////////////////////////////////////////////////////////////////
// Packetizer: output register stage that frames samples into packets
// and attaches the packet header to every beat
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module siggen_packetizer import siggen_pkg::*; (
  input  wire         ce_clk,
  input  wire         i_rst_n,
  input  siggen_cfg_t i_cfg,
  input  sample_t     i_sample,
  input  wire         i_valid,
  output logic        o_ready,
  output sample_t     o_tdata,
  output hdr_t        o_tuser,
  output logic        o_tlast,
  output logic        o_tvalid,
  input  wire         i_tready
);

  logic [15:0] beat_cnt;
  logic [11:0] seqnum;

  // Held for the rest of the packet
  logic [15:0] size_q;
  logic [15:0] src_q;
  logic [15:0] dst_q;

  logic        take;
  logic        first_beat;
  logic        last_beat;
  logic [15:0] cur_size;
  hdr_t        hdr_next;

  assign o_ready = !o_tvalid || i_tready;
  assign take    = i_valid && o_ready;

  // First beat reads the live config, later beats the latched copy
  assign first_beat = (beat_cnt == 16'd0);
  assign cur_size   = first_beat ? i_cfg.pkt_size : size_q;
  assign last_beat  = (beat_cnt == cur_size - 16'd1);

  always_comb begin
    hdr_next.seqnum  = seqnum;
    hdr_next.length  = {cur_size[13:0], 2'b00};
    hdr_next.src_sid = first_beat ? i_cfg.src_sid : src_q;
    hdr_next.dst_sid = first_beat ? i_cfg.dst_sid : dst_q;
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      o_tvalid <= 1'b0;
      beat_cnt <= '0;
      seqnum   <= '0;
    end else if (take) begin
      o_tvalid <= 1'b1;
      if (last_beat) begin
        beat_cnt <= '0;
        seqnum   <= seqnum + 12'd1;
      end else begin
        beat_cnt <= beat_cnt + 16'd1;
      end
    end else if (i_tready) begin
      o_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (take) begin
      o_tdata <= i_sample;
      o_tuser <= hdr_next;
      o_tlast <= last_beat;
      if (first_beat) begin
        size_q <= i_cfg.pkt_size;
        src_q  <= i_cfg.src_sid;
        dst_q  <= i_cfg.dst_sid;
      end
    end
  end

endmodule

`default_nettype wire

//--- siggen_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the signal generator: register map, waveform
// codes, stream and header structs, quarter-wave sine table
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package siggen_pkg;

  // User register map, above the shell register space
  localparam logic [7:0] SR_FREQ      = 8'd128;
  localparam logic [7:0] SR_SID       = 8'd129;
  localparam logic [7:0] SR_ENABLE    = 8'd132;
  localparam logic [7:0] SR_AMPLITUDE = 8'd138;
  localparam logic [7:0] SR_PKT_SIZE  = 8'd140;
  localparam logic [7:0] SR_WAVEFORM  = 8'd142;

  // Waveform codes, anything else is silent
  localparam logic [2:0] WAVE_CONST = 3'd0;
  localparam logic [2:0] WAVE_SINE  = 3'd1;

  // Samples per packet after reset
  localparam logic [15:0] DEF_PKT_SIZE = 16'd16;

  // Settings bus write, one cycle per strobe
  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  typedef struct packed {
    logic [31:0] freq;
    logic [31:0] amplitude;
    logic        enable;
    logic [2:0]  wave;
    logic [15:0] pkt_size;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } siggen_cfg_t;

  // I in the upper half, Q in the lower half
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } sample_t;

  // Length counts bytes, four per sample
  typedef struct packed {
    logic [11:0] seqnum;
    logic [15:0] length;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } hdr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Quarter-wave table, entry n is round(32767 * sin((2n+1) * pi / 256))
  // Half-step offset makes the cosine a plain mirror of the sine
  ////////////////////////////////////////////////////////////////////////////
  localparam int LUT_BITS = 6;

  localparam logic [14:0] SINE_LUT [0:(1<<LUT_BITS)-1] = '{
    15'd402,   15'd1206,  15'd2009,  15'd2811,  15'd3612,  15'd4410,  15'd5205,  15'd5998,
    15'd6786,  15'd7571,  15'd8351,  15'd9126,  15'd9896,  15'd10659, 15'd11417, 15'd12167,
    15'd12910, 15'd13645, 15'd14372, 15'd15090, 15'd15800, 15'd16499, 15'd17189, 15'd17869,
    15'd18537, 15'd19195, 15'd19841, 15'd20475, 15'd21096, 15'd21705, 15'd22301, 15'd22884,
    15'd23452, 15'd24007, 15'd24547, 15'd25072, 15'd25582, 15'd26077, 15'd26556, 15'd27019,
    15'd27466, 15'd27896, 15'd28310, 15'd28706, 15'd29085, 15'd29447, 15'd29791, 15'd30117,
    15'd30424, 15'd30714, 15'd30985, 15'd31237, 15'd31470, 15'd31685, 15'd31880, 15'd32057,
    15'd32213, 15'd32351, 15'd32469, 15'd32567, 15'd32646, 15'd32705, 15'd32745, 15'd32765
  };

endpackage

`default_nettype wire

//--- siggen_settings.sv
////////////////////////////////////////////////////////////////////////////
// Settings register file: decodes settings bus writes into the
// generator configuration
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module siggen_settings import siggen_pkg::*; (
  input  wire         ce_clk,
  input  wire         i_rst_n,
  input  set_bus_t    i_set,
  output siggen_cfg_t o_cfg
);

  logic [15:0] pkt_size_wr;

  // Zero-length packets are not allowed
  assign pkt_size_wr = (i_set.data[15:0] == 16'd0) ? 16'd1 : i_set.data[15:0];

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      o_cfg          <= '0;
      o_cfg.pkt_size <= DEF_PKT_SIZE;
    end else if (i_set.stb) begin
      case (i_set.addr)
        SR_FREQ: begin
          o_cfg.freq <= i_set.data;
        end
        SR_SID: begin
          // Source ID in the upper half, destination in the lower
          o_cfg.src_sid <= i_set.data[31:16];
          o_cfg.dst_sid <= i_set.data[15:0];
        end
        SR_ENABLE: begin
          o_cfg.enable <= i_set.data[0];
        end
        SR_AMPLITUDE: begin
          o_cfg.amplitude <= i_set.data;
        end
        SR_PKT_SIZE: begin
          o_cfg.pkt_size <= pkt_size_wr;
        end
        SR_WAVEFORM: begin
          o_cfg.wave <= i_set.data[2:0];
        end
        default: begin
          // Address belongs to another block
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- siggen_sine.sv
////////////////////////////////////////////////////////////////////////////
// Sine tone source: phase accumulator, quarter-wave lookup and amplitude
// scaling in a three-stage stall-all pipeline
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module siggen_sine import siggen_pkg::*; (
  input  wire         ce_clk,
  input  wire         i_rst_n,
  input  siggen_cfg_t i_cfg,
  output sample_t     o_sample,
  output logic        o_valid,
  input  wire         i_ready
);

  // Stage 1 is the accumulator itself
  logic [31:0] phase_acc;
  logic        ph_valid;
  sample_t     lut_q;
  logic        lut_valid;
  logic        advance;

  logic signed [15:0] amp;
  logic signed [31:0] prod_i;
  logic signed [31:0] prod_q;

  // Map a phase onto cosine and sine through the first-quadrant table
  function automatic sample_t quarter_lookup(input logic [31:0] phase);
    logic [1:0]          quad;
    logic [LUT_BITS-1:0] idx;
    logic [LUT_BITS-1:0] idx_rev;
    logic signed [15:0]  fwd;
    logic signed [15:0]  rev;
    sample_t             s;
    quad    = phase[31:30];
    idx     = phase[29 -: LUT_BITS];
    idx_rev = ~idx;
    fwd     = signed'({1'b0, SINE_LUT[idx]});
    rev     = signed'({1'b0, SINE_LUT[idx_rev]});
    case (quad)
      2'd0:    begin s.i =  rev; s.q =  fwd; end
      2'd1:    begin s.i = -fwd; s.q =  rev; end
      2'd2:    begin s.i = -rev; s.q = -fwd; end
      default: begin s.i =  fwd; s.q = -rev; end
    endcase
    return s;
  endfunction

  // Everything moves together, or nothing does
  assign advance = !o_valid || i_ready;

  assign amp    = signed'(i_cfg.amplitude[15:0]);
  assign prod_i = lut_q.i * amp;
  assign prod_q = lut_q.q * amp;

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n || !i_cfg.enable) begin
      phase_acc <= '0;
      ph_valid  <= 1'b0;
      lut_valid <= 1'b0;
      o_valid   <= 1'b0;
    end else if (advance) begin
      // Step only once the current phase moves on
      if (ph_valid) begin
        phase_acc <= phase_acc + i_cfg.freq;
      end
      ph_valid  <= 1'b1;
      lut_valid <= ph_valid;
      o_valid   <= lut_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (advance) begin
      lut_q      <= quarter_lookup(phase_acc);
      o_sample.i <= prod_i[30:15];
      o_sample.q <= prod_q[30:15];
    end
  end

endmodule

`default_nettype wire

//--- siggen_source_select.sv
////////////////////////////////////////////////////////////////////////////
// Constant source, waveform mux and enable gating
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module siggen_source_select import siggen_pkg::*; (
  input  siggen_cfg_t i_cfg,
  input  sample_t     i_sine,
  input  wire         i_sine_valid,
  input  wire         i_ready,
  output logic        o_sine_ready,
  output sample_t     o_sample,
  output logic        o_valid
);

  logic    sel_sine;
  logic    sel_const;
  sample_t const_sample;
  logic    src_valid;

  assign sel_sine  = (i_cfg.wave == WAVE_SINE);
  assign sel_const = (i_cfg.wave == WAVE_CONST);

  // Constant source repeats the amplitude register forever
  assign const_sample = sample_t'(i_cfg.amplitude);

  always_comb begin
    if (sel_sine) begin
      o_sample  = i_sine;
      src_valid = i_sine_valid;
    end else begin
      o_sample  = const_sample;
      src_valid = sel_const;
    end
  end

  // Unknown codes give nothing at all
  assign o_valid = src_valid && i_cfg.enable;

  // The constant source never stalls, so only the sine pipe sees ready
  assign o_sine_ready = sel_sine && i_ready;

endmodule

`default_nettype wire

//--- siggen_top.sv
////////////////////////////////////////////////////////////////////////////
// Signal generator top level: settings, sine source, selector, packetizer
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module siggen_top import siggen_pkg::*; (
  input  wire      ce_clk,
  input  wire      i_rst_n,
  input  set_bus_t i_set,
  output sample_t  o_tdata,
  output hdr_t     o_tuser,
  output logic     o_tlast,
  output logic     o_tvalid,
  input  wire      i_tready
);

  siggen_cfg_t cfg;
  sample_t     sine_sample;
  logic        sine_valid;
  logic        sine_ready;
  sample_t     sel_sample;
  logic        sel_valid;
  logic        sel_ready;

  siggen_settings u_settings (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_set(i_set), .o_cfg(cfg)
  );

  siggen_sine u_sine (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_cfg(cfg),
    .o_sample(sine_sample), .o_valid(sine_valid), .i_ready(sine_ready)
  );

  // Combinational, so the packetizer register is the only output stage
  siggen_source_select u_select (
    .i_cfg(cfg), .i_sine(sine_sample), .i_sine_valid(sine_valid), .i_ready(sel_ready),
    .o_sine_ready(sine_ready), .o_sample(sel_sample), .o_valid(sel_valid)
  );

  siggen_packetizer u_packetizer (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_cfg(cfg),
    .i_sample(sel_sample), .i_valid(sel_valid), .o_ready(sel_ready),
    .o_tdata(o_tdata), .o_tuser(o_tuser), .o_tlast(o_tlast), .o_tvalid(o_tvalid),
    .i_tready(i_tready)
  );

endmodule

`default_nettype wire

//--- tb_siggen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the signal generator: register writes, random back-pressure,
// reference model for samples and headers, stream assertions
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_siggen import siggen_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 6000;

  logic     ce_clk;
  logic     i_rst_n;
  set_bus_t i_set;
  sample_t  o_tdata;
  hdr_t     o_tuser;
  logic     o_tlast;
  logic     o_tvalid;
  logic     i_tready;

  int          seed = 32'hcd36_85c9;
  logic [31:0] rnd;
  int          cycle_cnt;
  int          beat_count;
  int          mismatch_cnt;
  int          fail_cnt;
  string       test_name;

  // Shadow registers and model state
  logic [31:0] m_freq;
  logic [31:0] m_amp;
  logic [15:0] m_pkt_size;
  logic [15:0] m_src;
  logic [15:0] m_dst;
  logic [2:0]  m_wave;
  logic [31:0] sine_k;
  logic [15:0] pkt_pos;
  logic [15:0] size_lat;
  logic [15:0] src_lat;
  logic [15:0] dst_lat;
  logic [11:0] exp_seq;

  siggen_top i_siggen_top (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_set(i_set),
    .o_tdata(o_tdata), .o_tuser(o_tuser), .o_tlast(o_tlast), .o_tvalid(o_tvalid),
    .i_tready(i_tready)
  );

  initial begin
    ce_clk = 1'b0;
    forever #50 ce_clk = ~ce_clk;
  end

  // Back-pressure, ready about three cycles in four
  always @(negedge ce_clk) begin
    rnd = $random(seed);
    i_tready <= (rnd[1:0] != 2'b00);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stream assertions
  ////////////////////////////////////////////////////////////////////////////
  assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tuser)
                                 && $stable(o_tlast)))
    else begin
      fail_cnt++;
      $display("%s: output beat changed while stalled", test_name);
    end

  assert property (@(posedge ce_clk) !i_rst_n |=> !o_tvalid)
    else begin
      fail_cnt++;
      $display("%s: o_tvalid high during reset", test_name);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  // Sine by quadrant folding, cosine is the sine a quarter turn ahead
  function automatic logic signed [15:0] quadrant_sine(input logic [31:0] ph);
    logic [5:0]         n;
    logic signed [15:0] mag;
    n = ph[29:24];
    if (ph[30]) mag = signed'({1'b0, SINE_LUT[6'd63 - n]});
    else mag = signed'({1'b0, SINE_LUT[n]});
    return ph[31] ? -mag : mag;
  endfunction

  function automatic logic [15:0] scale_amp(input logic signed [15:0] v);
    logic signed [15:0] a;
    int                 prod;
    a    = m_amp[15:0];
    prod = v * a;
    prod = prod >>> 15;
    return prod[15:0];
  endfunction

  function automatic logic [31:0] tone_ref(input logic [31:0] ph);
    return {scale_amp(quadrant_sine(ph + 32'h4000_0000)), scale_amp(quadrant_sine(ph))};
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act)
      else begin
        mismatch_cnt++;
        $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
  endtask

  task automatic check_beat();
    logic [31:0] exp_data;
    hdr_t        exp_hdr;
    logic        exp_last;
    if (pkt_pos == 16'd0) begin
      size_lat = m_pkt_size;
      src_lat  = m_src;
      dst_lat  = m_dst;
    end
    if (m_wave == WAVE_SINE) begin
      exp_data = tone_ref(sine_k * m_freq);
      sine_k   = sine_k + 32'd1;
    end else begin
      exp_data = m_amp;
    end
    exp_last        = (pkt_pos == size_lat - 16'd1);
    exp_hdr.seqnum  = exp_seq;
    exp_hdr.length  = size_lat << 2;
    exp_hdr.src_sid = src_lat;
    exp_hdr.dst_sid = dst_lat;
    check_value("tdata", 64'(exp_data), 64'(o_tdata));
    check_value("tuser", 64'(exp_hdr), 64'(o_tuser));
    check_value("tlast", 64'(exp_last), 64'(o_tlast));
    if (exp_last) begin
      pkt_pos = 16'd0;
      exp_seq = exp_seq + 12'd1;
    end else begin
      pkt_pos = pkt_pos + 16'd1;
    end
  endtask

  always @(posedge ce_clk) begin
    if (i_rst_n && o_tvalid && i_tready) begin
      check_beat();
      beat_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic set_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge ce_clk);
    i_set = '{stb: 1'b1, addr: addr, data: data};
    case (addr)
      SR_FREQ:      m_freq = data;
      SR_AMPLITUDE: m_amp = data;
      SR_PKT_SIZE:  m_pkt_size = (data[15:0] == 16'd0) ? 16'd1 : data[15:0];
      SR_SID: begin
        m_src = data[31:16];
        m_dst = data[15:0];
      end
      default: begin
      end
    endcase
    @(negedge ce_clk);
    i_set.stb = 1'b0;
  endtask

  task automatic wait_beats(input int n);
    int target;
    target = beat_count + n;
    while (beat_count < target) @(negedge ce_clk);
  endtask

  // In-flight beats may still drain, then the output must go quiet
  task automatic expect_drain();
    int start;
    int settled;
    start = beat_count;
    repeat (20) @(negedge ce_clk);
    settled = beat_count;
    assert (settled - start <= 3)
      else begin
        fail_cnt++;
        $display("%s: %0d beats after gating, at most 3 allowed", test_name, settled - start);
      end
    repeat (40) @(negedge ce_clk);
    assert (beat_count == settled)
      else begin
        fail_cnt++;
        $display("%s: output kept producing beats after gating", test_name);
      end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge ce_clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, test %s did not finish", TIMEOUT_CYCLES, test_name);
    $display("Test failures found");
    $finish;
  end

  initial begin
    i_rst_n      = 1'b0;
    i_set        = '0;
    i_tready     = 1'b0;
    beat_count   = 0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    test_name    = "reset";
    m_freq       = '0;
    m_amp        = '0;
    m_pkt_size   = DEF_PKT_SIZE;
    m_src        = '0;
    m_dst        = '0;
    m_wave       = WAVE_CONST;
    sine_k       = '0;
    pkt_pos      = '0;
    size_lat     = '0;
    src_lat      = '0;
    dst_lat      = '0;
    exp_seq      = '0;
    repeat (8) @(posedge ce_clk);
    @(negedge ce_clk);
    i_rst_n = 1'b1;

    // Idle with enable at zero
    repeat (20) begin
      @(negedge ce_clk);
      assert (!o_tvalid)
        else begin
          fail_cnt++;
          $display("%s: o_tvalid high with enable off", test_name);
        end
    end

    test_name = "const";
    set_reg(SR_SID, 32'h0012_0034);
    set_reg(SR_AMPLITUDE, 32'h1234_abcd);
    set_reg(SR_PKT_SIZE, 32'd8);
    set_reg(SR_WAVEFORM, 32'(WAVE_CONST));
    set_reg(SR_ENABLE, 32'd1);
    wait_beats(24);

    // Size write three beats into a packet
    test_name = "pkt_size";
    wait_beats(3);
    set_reg(SR_PKT_SIZE, 32'd5);
    wait_beats(20);

    test_name = "gate_wave";
    set_reg(SR_WAVEFORM, 32'd3);
    expect_drain();
    set_reg(SR_ENABLE, 32'd0);

    test_name = "sine";
    set_reg(SR_SID, 32'h0abc_0def);
    set_reg(SR_PKT_SIZE, 32'd16);
    set_reg(SR_FREQ, 32'h0345_6789);
    set_reg(SR_AMPLITUDE, 32'h0000_6000);
    set_reg(SR_WAVEFORM, 32'(WAVE_SINE));
    m_wave = WAVE_SINE;
    sine_k = '0;
    set_reg(SR_ENABLE, 32'd1);
    wait_beats(64);

    test_name = "gate_enable";
    set_reg(SR_ENABLE, 32'd0);
    expect_drain();

    $display("Summary: %0d beats checked, %0d mismatches, %0d other errors",
             beat_count, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
